// ==== design/nnPkg.sv ====
package nnPkg;

	// Datapath width for weights, activations and the accumulator.
	localparam int WORD_BITS = 32;

	// Activations feeding each neuron.
	localparam int IN_COUNT = 15;

	// One row per neuron: the weights, then the bias word.
	localparam int ROW_WORDS = IN_COUNT + 1;

	// Wide enough to count a full row, bias slot included.
	localparam int IN_IDX_BITS = 4;

	// Fixed-point output slice taken from the sum.
	localparam int FRAC_BITS = 13;
	localparam int OUT_BITS = 16;

endpackage

// ==== design/weightRom.sv ====
`timescale 1ns/1ns

module weightRom
#(
	parameter int NEURONS = 4,
	localparam int ADDR_BITS = $clog2(NEURONS * nnPkg::ROW_WORDS)
)
(
	input logic clk,
	input logic [ADDR_BITS-1:0] addr,
	output logic [nnPkg::WORD_BITS-1:0] data
);

	import nnPkg::*;

	localparam int DEPTH = NEURONS * ROW_WORDS;

	// Row n holds neuron n's weights followed by its bias.
	logic [WORD_BITS-1:0] mem [DEPTH];

	initial
	begin
		$readmemh("weights.hex", mem);
	end

	always_ff @(posedge clk)
	begin
		data <= mem[addr]; // One cycle read latency.
	end

endmodule

// ==== design/weightArbiter.sv ====
`timescale 1ns/1ns

module weightArbiter
#(
	parameter int NEURONS = 4,
	localparam int ADDR_BITS = $clog2(NEURONS * nnPkg::ROW_WORDS),
	localparam int PTR_BITS = (NEURONS > 1) ? $clog2(NEURONS) : 1
)
(
	input logic clk,
	input logic reset,
	input logic [NEURONS-1:0] reqValid,
	input logic [NEURONS-1:0][ADDR_BITS-1:0] reqAddr,
	output logic [NEURONS-1:0] grant,
	output logic [ADDR_BITS-1:0] memAddr,
	input logic [nnPkg::WORD_BITS-1:0] memData,
	output logic [NEURONS-1:0] rdValid,
	output logic [nnPkg::WORD_BITS-1:0] rdData
);

	logic [PTR_BITS-1:0] ptr; // Highest priority requester this cycle.
	logic [PTR_BITS-1:0] grantIdx;
	logic found;

	always_comb
	begin
		int idx;
		grant = '0;
		grantIdx = ptr;
		found = 1'b0;
		for (int i = 0; i < NEURONS; i++)
		begin
			idx = int'(ptr) + i;
			if (idx >= NEURONS)
				idx = idx - NEURONS;
			if (!found && reqValid[idx])
			begin
				found = 1'b1;
				grantIdx = PTR_BITS'(idx);
			end
		end
		if (found)
			grant[grantIdx] = 1'b1;
	end

	assign memAddr = reqAddr[grantIdx];
	assign rdData = memData; // Shared return bus.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ptr <= '0;
			rdValid <= '0;
		end
		else
		begin
			rdValid <= grant; // Lines up with the memory latency.
			if (found)
				ptr <= (grantIdx == PTR_BITS'(NEURONS - 1)) ? '0 : grantIdx + 1'b1;
		end
	end

	grantOneHot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
		else $error("Arbiter granted more than one neuron");

	grantHasRequest: assert property (@(posedge clk) disable iff (reset)
		(grant & ~reqValid) == '0)
		else $error("Grant to a neuron without a request");

endmodule

// ==== design/activationBuffer.sv ====
`timescale 1ns/1ns

module activationBuffer
#(
	parameter int NEURONS = 4
)
(
	input logic clk,
	input logic reset,
	input logic inWrite,
	input logic [nnPkg::IN_IDX_BITS-1:0] inIndex,
	input logic [nnPkg::WORD_BITS-1:0] inData,
	input logic [NEURONS-1:0][nnPkg::IN_IDX_BITS-1:0] actIndex,
	output logic [NEURONS-1:0][nnPkg::WORD_BITS-1:0] actData
);

	import nnPkg::*;

	logic [WORD_BITS-1:0] regs [IN_COUNT];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < IN_COUNT; i++)
				regs[i] <= '0;
		end
		else if (inWrite)
			regs[inIndex] <= inData;
	end

	// Index 15 is the bias slot, so it reads as zero.
	always_comb
	begin
		for (int n = 0; n < NEURONS; n++)
		begin
			if (actIndex[n] < IN_IDX_BITS'(IN_COUNT))
				actData[n] = regs[actIndex[n]];
			else
				actData[n] = '0;
		end
	end

	indexInRange: assert property (@(posedge clk) disable iff (reset)
		inWrite |-> inIndex < IN_IDX_BITS'(IN_COUNT))
		else $error("Activation write index out of range");

endmodule

// ==== design/neuronMac.sv ====
`timescale 1ns/1ns

module neuronMac
#(
	parameter int ADDR_BITS = 6,
	parameter int ROW_BASE = 0
)
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic reqValid,
	output logic [ADDR_BITS-1:0] reqAddr,
	input logic grant,
	input logic rdValid,
	input logic [nnPkg::WORD_BITS-1:0] rdData,
	output logic [nnPkg::IN_IDX_BITS-1:0] actIndex,
	input logic [nnPkg::WORD_BITS-1:0] actData,
	output logic done,
	output logic [nnPkg::OUT_BITS-1:0] result
);

	import nnPkg::*;

	localparam logic [ADDR_BITS-1:0] BASE_ADDR = ADDR_BITS'(ROW_BASE);
	localparam logic [IN_IDX_BITS-1:0] BIAS_SLOT = IN_IDX_BITS'(ROW_WORDS - 1);

	logic busy;
	logic [IN_IDX_BITS:0] reqCnt; // Reaches ROW_WORDS once all are issued.
	logic [IN_IDX_BITS-1:0] retCnt;
	logic [WORD_BITS-1:0] acc;
	logic [WORD_BITS-1:0] product;
	logic [WORD_BITS-1:0] addend;
	logic [WORD_BITS-1:0] sum;
	logic [OUT_BITS-1:0] reluOut;
	logic lastReturn;

	// Requests stay put until granted.
	assign reqValid = busy && (reqCnt < (IN_IDX_BITS + 1)'(ROW_WORDS));
	assign reqAddr = BASE_ADDR + ADDR_BITS'(reqCnt[IN_IDX_BITS-1:0]);

	// Returns come back in order, so the return count selects the activation.
	assign actIndex = retCnt;

	assign product = rdData * actData; // Truncated to 32 bits.
	assign addend = (retCnt == BIAS_SLOT) ? rdData : product;
	assign sum = acc + addend;
	assign lastReturn = rdValid && (retCnt == BIAS_SLOT);

	// Negative sums clamp to zero.
	always_comb
	begin
		if (sum[WORD_BITS-1])
			reluOut = '0;
		else
			reluOut = sum[FRAC_BITS+OUT_BITS-1:FRAC_BITS];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			reqCnt <= '0;
			retCnt <= '0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (start && !busy)
			begin
				busy <= 1'b1;
				reqCnt <= '0;
				retCnt <= '0;
			end
			else if (busy)
			begin
				if (grant)
					reqCnt <= reqCnt + 1'b1;
				if (rdValid)
					retCnt <= retCnt + 1'b1;
				if (lastReturn)
				begin
					busy <= 1'b0;
					result <= reluOut;
					done <= 1'b1;
				end
			end
		end
	end

	// Accumulator clears on start and adds one term per return.
	always_ff @(posedge clk)
	begin
		if (start && !busy)
			acc <= '0;
		else if (rdValid)
			acc <= sum;
	end

	noStartWhileBusy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy)
		else $error("Neuron at base %0d started while busy", ROW_BASE);

endmodule

// ==== design/layerTop.sv ====
`timescale 1ns/1ns

module layerTop
#(
	parameter int NEURONS = 4,
	localparam int ADDR_BITS = $clog2(NEURONS * nnPkg::ROW_WORDS)
)
(
	input logic clk,
	input logic reset,
	input logic inWrite,
	input logic [nnPkg::IN_IDX_BITS-1:0] inIndex,
	input logic [nnPkg::WORD_BITS-1:0] inData,
	input logic start,
	output logic layerDone,
	output logic [NEURONS-1:0][nnPkg::OUT_BITS-1:0] result
);

	import nnPkg::*;

	logic [NEURONS-1:0] reqValid;
	logic [NEURONS-1:0][ADDR_BITS-1:0] reqAddr;
	logic [NEURONS-1:0] grant;
	logic [NEURONS-1:0] rdValid;
	logic [WORD_BITS-1:0] rdData;
	logic [ADDR_BITS-1:0] memAddr;
	logic [WORD_BITS-1:0] memData;
	logic [NEURONS-1:0][IN_IDX_BITS-1:0] actIndex;
	logic [NEURONS-1:0][WORD_BITS-1:0] actData;
	logic [NEURONS-1:0] done;
	logic [NEURONS-1:0] finished; // Sticky per-neuron completion.
	logic [NEURONS-1:0] nextFinished;

	assign nextFinished = finished | done;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			finished <= '0;
			layerDone <= 1'b0;
		end
		else if (&nextFinished)
		begin
			finished <= '0;
			layerDone <= 1'b1;
		end
		else
		begin
			finished <= nextFinished;
			layerDone <= 1'b0;
		end
	end

	weightRom #(.NEURONS(NEURONS)) rom_i (.clk(clk), .addr(memAddr), .data(memData));

	weightArbiter #(.NEURONS(NEURONS)) arbiter_i
	(
		.clk(clk), .reset(reset),
		.reqValid(reqValid), .reqAddr(reqAddr), .grant(grant),
		.memAddr(memAddr), .memData(memData),
		.rdValid(rdValid), .rdData(rdData)
	);

	activationBuffer #(.NEURONS(NEURONS)) buffer_i
	(
		.clk(clk), .reset(reset),
		.inWrite(inWrite), .inIndex(inIndex), .inData(inData),
		.actIndex(actIndex), .actData(actData)
	);

	for (genvar n = 0; n < NEURONS; n++)
	begin : neuronGen
		neuronMac #(.ADDR_BITS(ADDR_BITS), .ROW_BASE(n * ROW_WORDS)) neuron_i
		(
			.clk(clk), .reset(reset), .start(start),
			.reqValid(reqValid[n]), .reqAddr(reqAddr[n]), .grant(grant[n]),
			.rdValid(rdValid[n]), .rdData(rdData),
			.actIndex(actIndex[n]), .actData(actData[n]),
			.done(done[n]), .result(result[n])
		);
	end

endmodule

// ==== tests/layerTb.sv ====
`timescale 1ns/1ns

module layerTb;

	import nnPkg::*;

	localparam int NEURONS = 4;
	localparam int RESET_CYCLES = 8;
	localparam int RUNS = 8;
	localparam int TIMEOUT_CYCLES = RUNS * 200 + RESET_CYCLES;

	localparam int VEC_ZERO = 0;
	localparam int VEC_SIGNED = 1;
	localparam int VEC_POSITIVE = 2;
	localparam int VEC_AGAINST0 = 3;

	logic clk;
	logic reset;
	logic inWrite;
	logic [IN_IDX_BITS-1:0] inIndex;
	logic [WORD_BITS-1:0] inData;
	logic start;
	logic layerDone;
	logic [NEURONS-1:0][OUT_BITS-1:0] result;

	logic [WORD_BITS-1:0] refWeights [NEURONS * ROW_WORDS];
	logic [WORD_BITS-1:0] acts [IN_COUNT]; // Copy of what the buffer holds.
	logic [OUT_BITS-1:0] expected [NEURONS];
	logic [31:0] lcgState = 32'd61069;
	logic started = 1'b0;
	logic running = 1'b0; // A layer run is outstanding.
	int errors = 0;
	int runCount = 0;
	int cycleCount = 0;

	layerTop #(.NEURONS(NEURONS)) dut_i
	(
		.clk(clk), .reset(reset),
		.inWrite(inWrite), .inIndex(inIndex), .inData(inData),
		.start(start), .layerDone(layerDone), .result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// Wrapping dot product plus bias, then the ReLU slice.
	function automatic logic [OUT_BITS-1:0] modelNeuron(int n);
		logic [WORD_BITS-1:0] sum;
		sum = refWeights[n * ROW_WORDS + IN_COUNT];
		for (int i = 0; i < IN_COUNT; i++)
			sum = sum + refWeights[n * ROW_WORDS + i] * acts[i];
		if (sum[WORD_BITS-1])
			return '0;
		else
			return sum[FRAC_BITS+OUT_BITS-1:FRAC_BITS];
	endfunction

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic writeActivation(int idx, logic [WORD_BITS-1:0] value);
		inWrite = 1'b1;
		inIndex = IN_IDX_BITS'(idx);
		inData = value;
		acts[idx] = value;
		tick();
		inWrite = 1'b0;
	endtask

	task automatic loadVector(int kind);
		logic [31:0] r;
		logic [WORD_BITS-1:0] value;
		for (int i = 0; i < IN_COUNT; i++)
		begin
			r = nextRandom();
			case (kind)
				VEC_SIGNED: value = {{24{r[23]}}, r[23:16]};
				VEC_POSITIVE: value = {26'd0, r[21:16]};
				// Opposes the sign of each neuron 0 weight.
				VEC_AGAINST0: value = refWeights[i][WORD_BITS-1] ? 32'd60 : 32'hFFFF_FFC4;
				default: value = '0;
			endcase
			writeActivation(i, value);
		end
	endtask

	task automatic runLayer();
		for (int n = 0; n < NEURONS; n++)
			expected[n] = modelNeuron(n);
		started = 1'b1;
		running = 1'b1;
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!layerDone)
			tick();
		tick(); // Checkers sample the pulse here.
		running = 1'b0;
		runCount++;
	endtask

	task automatic reportAndFinish();
		$display("Layer runs: %0d, errors: %0d", runCount, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	doneOnlyWhenRunning: assert property (@(posedge clk) disable iff (reset)
		layerDone |-> running)
		else
		begin
			errors++;
			$display("layerDone pulsed with no layer run outstanding");
		end

	for (genvar n = 0; n < NEURONS; n++)
	begin : checkGen
		zeroBeforeStart: assert property (@(posedge clk) disable iff (reset)
			!started |-> result[n] == '0)
			else
			begin
				errors++;
				$display("Mismatch result[%0d]: expected %h, got %h", n, 16'h0000,
					$sampled(result[n]));
			end

		matchesModel: assert property (@(posedge clk) disable iff (reset)
			layerDone |-> result[n] == expected[n])
			else
			begin
				errors++;
				$display("Mismatch result[%0d]: expected %h, got %h", n,
					$sampled(expected[n]), $sampled(result[n]));
			end

		holdsWhenIdle: assert property (@(posedge clk) disable iff (reset)
			!running |-> $stable(result[n]))
			else
			begin
				errors++;
				$display("Mismatch result[%0d]: expected %h, got %h", n,
					$past(result[n]), $sampled(result[n]));
			end
	end

	initial
	begin
		while (cycleCount < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: layer runs did not finish within %0d cycles", TIMEOUT_CYCLES);
		errors++;
		reportAndFinish();
	end

	initial
	begin
		reset = 1'b1;
		inWrite = 1'b0;
		inIndex = '0;
		inData = '0;
		start = 1'b0;
		$readmemh("weights.hex", refWeights);
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset = 1'b0;
		repeat (5) tick(); // Idle, outputs must stay cleared.
		loadVector(VEC_ZERO); // Biases alone.
		runLayer();
		loadVector(VEC_SIGNED);
		runLayer();
		loadVector(VEC_POSITIVE);
		runLayer();
		loadVector(VEC_AGAINST0);
		runLayer();
		// Back-to-back runs.
		for (int r = 0; r < 4; r++)
		begin
			loadVector(VEC_SIGNED);
			runLayer();
		end
		repeat (5) tick();
		reportAndFinish();
	end

endmodule

// ==== sim.f ====
design/nnPkg.sv
design/weightRom.sv
design/weightArbiter.sv
design/activationBuffer.sv
design/neuronMac.sv
design/layerTop.sv
tests/layerTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the layer testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module layerTb -f sim.f \
	-o layerSim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see build.log"
	exit 1
fi

./obj_dir/layerSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported failures, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== weights.hex ====
// One 32-bit two's-complement word per line: 15 weights, then the bias, for neurons 0 to 3.
00000C80
FFFFF600
00000640
000012C0
FFFFFB00
00000960
FFFFF060
00000320
00000A00
FFFFFCE0
00001000
FFFFF9C0
000007D0
00000190
FFFFF380
00030000
FFFFF830
00000BB8
000005DC
FFFFFA24
00000FA0
000002EE
FFFFF448
00000DAC
000003E8
FFFFFE0C
000009C4
00001388
FFFFF63C
00000708
000004B0
FFFF0000
00000100
00000200
00000300
00000400
00000500
00000600
00000700
00000800
00000900
00000A00
00000B00
00000C00
00000D00
00000E00
00000F00
00002000
FFFFF000
FFFFF800
00002000
FFFFFC00
00001800
FFFFE000
00000800
FFFFF400
00001400
FFFFEC00
00000C00
FFFFF000
00002400
FFFFFF00
00000400
10004000
